/* source/fp_add_cfg.svh */
/*
 fp adder configuration macros.
 single precision format widths, exponent bias and pipeline depth.
*/
`ifndef FP_ADD_CFG_SVH
`define FP_ADD_CFG_SVH

// ieee 754 single precision layout.
`define FP_EXP_W   8
`define FP_FRAC_W  23
`define FP_BIAS    127
`define FP_WORD_W  32

// hidden bit, fraction, then guard, round and sticky.
`define FP_EXT_W   (`FP_FRAC_W + 4)

// req to ack in clock cycles.
`define FP_LATENCY 3

`endif

/* source/fp_add_pkg.sv */
/*
 fp adder types.
 float word view and the records passed between pipeline stages.
*/
`default_nettype none

`include "fp_add_cfg.svh"

package fp_add_pkg;

    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_FRAC_W-1:0] frac;
    } fp_fields_t;

    // same word, raw or split into fields.
    typedef union packed {
        logic [`FP_WORD_W-1:0] bits;
        fp_fields_t            fields;
    } fp_word_u;

    // after alignment.
    typedef struct packed {
        logic                 valid;
        logic                 eff_sub;    // signs differ.
        logic                 sign;       // sign of larger magnitude.
        logic [`FP_EXP_W-1:0] exp;        // larger exponent.
        logic [`FP_EXT_W-1:0] mant_big;
        logic [`FP_EXT_W-1:0] mant_small; // already shifted, sticky in bit 0.
        logic                 zero;       // both operands zero.
    } aligned_t;

    // after add and normalize.
    typedef struct packed {
        logic                        valid;
        logic                        sign;
        // two extra bits so over/underflow stay visible.
        logic signed [`FP_EXP_W+1:0] exp;
        logic [`FP_EXT_W-1:0]        mant;
        logic                        zero;
    } normed_t;

endpackage

`default_nettype wire

/* source/fp_align.sv */
/*
 fp adder input stage.
 unpacks both operands, orders them by magnitude and aligns the smaller one.
*/
`default_nettype none

`include "fp_add_cfg.svh"

module fp_align import fp_add_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     req,
    input  wire fp_word_u a,
    input  wire fp_word_u b,
    output aligned_t      stage1
);

    logic                                a_zero;
    logic                                b_zero;
    logic [`FP_EXP_W+`FP_FRAC_W-1:0]     a_mag;
    logic [`FP_EXP_W+`FP_FRAC_W-1:0]     b_mag;
    logic                                a_big;
    fp_word_u                            op_big;
    fp_word_u                            op_small;
    logic                                big_zero;
    logic                                small_zero;
    logic [`FP_EXP_W-1:0]                exp_diff;
    logic [`FP_EXT_W-1:0]                mant_big;
    logic [`FP_EXT_W-1:0]                mant_small;
    logic [`FP_EXT_W-1:0]                lost_mask;
    logic [`FP_EXT_W-1:0]                small_shift;

    // exponent zero means zero, denormals included.
    assign a_zero = (a.fields.exp == '0);
    assign b_zero = (b.fields.exp == '0);

    // exponent and fraction compare as one unsigned magnitude.
    assign a_mag = a_zero ? '0 : a.bits[`FP_WORD_W-2:0];
    assign b_mag = b_zero ? '0 : b.bits[`FP_WORD_W-2:0];
    assign a_big = (a_mag >= b_mag);

    assign op_big     = a_big ? a : b;
    assign op_small   = a_big ? b : a;
    assign big_zero   = a_big ? a_zero : b_zero;
    assign small_zero = a_big ? b_zero : a_zero;

    // hidden bit on top, three empty bits for guard, round, sticky.
    assign mant_big   = big_zero ? '0 : {1'b1, op_big.fields.frac, 3'b000};
    assign mant_small = small_zero ? '0 : {1'b1, op_small.fields.frac, 3'b000};

    assign exp_diff  = op_big.fields.exp - op_small.fields.exp;
    assign lost_mask = ~({`FP_EXT_W{1'b1}} << exp_diff); // bits falling off the end.

    always_comb begin
        if (exp_diff >= `FP_EXT_W) begin
            small_shift = {{(`FP_EXT_W-1){1'b0}}, |mant_small}; // only sticky left.
        end else begin
            small_shift    = mant_small >> exp_diff;
            small_shift[0] = small_shift[0] | (|(mant_small & lost_mask));
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage1 <= '0;
        end else begin
            stage1.valid      <= req;
            stage1.eff_sub    <= a.fields.sign ^ b.fields.sign;
            stage1.sign       <= op_big.fields.sign;
            stage1.exp        <= op_big.fields.exp;
            stage1.mant_big   <= mant_big;
            stage1.mant_small <= small_shift;
            stage1.zero       <= a_zero & b_zero;
        end
    end

endmodule

`default_nettype wire

/* source/fp_mant_add.sv */
/*
 fp adder middle stage.
 adds or subtracts the aligned mantissas and renormalizes the result.
*/
`default_nettype none

`include "fp_add_cfg.svh"

module fp_mant_add import fp_add_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire aligned_t stage1,
    output normed_t       stage2
);

    localparam int NW   = `FP_EXP_W + 2;            // working exponent width.
    localparam int LZ_W = $clog2(`FP_EXT_W + 1);    // holds a count of 0..27.

    logic [`FP_EXT_W:0]     sum;
    logic                   carry;
    logic                   sum_zero;
    logic [LZ_W-1:0]        lz;
    logic signed [NW-1:0]   exp_in;
    logic signed [NW-1:0]   exp_norm;
    logic [`FP_EXT_W-1:0]   mant_norm;

    // position of the top set bit, counted from the msb.
    function automatic logic [LZ_W-1:0] lead_zeros(input logic [`FP_EXT_W-1:0] v);
        logic [LZ_W-1:0] n;
        n = LZ_W'(`FP_EXT_W);
        for (int i = 0; i < `FP_EXT_W; i++) begin
            if (v[i]) begin
                n = LZ_W'(`FP_EXT_W - 1 - i); // higher bits win.
            end
        end
        return n;
    endfunction

    // big is never below small, so the difference stays positive.
    always_comb begin
        if (stage1.eff_sub) begin
            sum = {1'b0, stage1.mant_big} - {1'b0, stage1.mant_small};
        end else begin
            sum = {1'b0, stage1.mant_big} + {1'b0, stage1.mant_small};
        end
    end

    assign carry    = sum[`FP_EXT_W];
    assign sum_zero = (sum == '0);
    assign lz       = lead_zeros(sum[`FP_EXT_W-1:0]);
    assign exp_in   = signed'(NW'(stage1.exp));

    always_comb begin
        if (carry) begin
            // one step right, the dropped bit folds into sticky.
            mant_norm = {sum[`FP_EXT_W:2], sum[1] | sum[0]};
            exp_norm  = exp_in + NW'(1);
        end else begin
            // after cancellation. sticky moves up with the rest.
            mant_norm = sum[`FP_EXT_W-1:0] << lz;
            exp_norm  = exp_in - signed'(NW'(lz));
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage2 <= '0;
        end else begin
            stage2.valid <= stage1.valid;
            stage2.sign  <= (stage1.zero | sum_zero) ? 1'b0 : stage1.sign; // exact zero is +0.
            stage2.exp   <= exp_norm;
            stage2.mant  <= mant_norm;
            stage2.zero  <= stage1.zero | sum_zero;
        end
    end

endmodule

`default_nettype wire

/* source/fp_round_pack.sv */
/*
 fp adder output stage.
 round to nearest even, clamp to infinity or zero, pack and register the result.
*/
`default_nettype none

`include "fp_add_cfg.svh"

module fp_round_pack import fp_add_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire normed_t stage2,
    output logic         ack,
    output fp_word_u     out
);

    localparam int NW = `FP_EXP_W + 2;
    localparam int RW = `FP_FRAC_W + 2;                           // carry, hidden, fraction.
    localparam logic signed [NW-1:0] EXP_INF = NW'(2 * `FP_BIAS + 1); // all ones exponent.

    logic                   lsb;
    logic                   guard;
    logic                   rnd;
    logic                   sticky;
    logic                   round_up;
    logic [RW-1:0]          rounded;
    logic signed [NW-1:0]   exp_rnd;
    logic [`FP_FRAC_W-1:0]  frac_rnd;
    fp_word_u               result;

    assign lsb    = stage2.mant[3];
    assign guard  = stage2.mant[2];
    assign rnd    = stage2.mant[1];
    assign sticky = stage2.mant[0];

    // ties go to the even fraction.
    assign round_up = guard & (rnd | sticky | lsb);
    assign rounded  = {1'b0, stage2.mant[`FP_EXT_W-1:3]} + RW'(round_up);

    // 1.111..1 rounding up becomes 10.000..0.
    assign exp_rnd  = stage2.exp + NW'(rounded[RW-1]);
    assign frac_rnd = rounded[`FP_FRAC_W-1:0]; // all zero after that carry.

    always_comb begin
        result.bits = '0;
        if (stage2.zero) begin
            result.bits = '0;
        end else if (exp_rnd >= EXP_INF) begin
            result.fields.sign = stage2.sign; // signed infinity.
            result.fields.exp  = '1;
        end else if (exp_rnd <= 0) begin
            result.fields.sign = stage2.sign; // flush to zero.
        end else begin
            result.fields.sign = stage2.sign;
            result.fields.exp  = exp_rnd[`FP_EXP_W-1:0];
            result.fields.frac = frac_rnd;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack      <= 1'b0;
            out.bits <= '0;
        end else begin
            ack <= stage2.valid;
            if (stage2.valid) begin
                out <= result; // held until the next ack.
            end
        end
    end

endmodule

`default_nettype wire

/* source/float_add_pipeline.sv */
/*
 pipelined single precision adder.
 req/ack strobes, fixed three cycle latency, one new operand pair per cycle.
*/
`default_nettype none

module float_add_pipeline import fp_add_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     req,
    input  wire fp_word_u a,
    input  wire fp_word_u b,
    output logic          ack,
    output fp_word_u      out
);

    aligned_t stage1; // ordered and aligned operands.
    normed_t  stage2; // normalized sum before rounding.

    fp_align u_align (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .a      (a),
        .b      (b),
        .stage1 (stage1)
    );

    fp_mant_add u_mant_add (
        .clk    (clk),
        .rst    (rst),
        .stage1 (stage1),
        .stage2 (stage2)
    );

    fp_round_pack u_round_pack (
        .clk    (clk),
        .rst    (rst),
        .stage2 (stage2),
        .ack    (ack),
        .out    (out)
    );

endmodule

`default_nettype wire

/* verif/float_add_chk.sv */
/*
 handshake and result checker for the float adder.
 fixed latency, no stray ack, quiet during reset, stable result.
*/
`default_nettype none

`include "fp_add_cfg.svh"

module float_add_chk (
    input wire logic                  clk,
    input wire logic                  rst,
    input wire logic                  req,
    input wire logic                  ack,
    input wire logic [`FP_WORD_W-1:0] out
);

    timeunit 1ns;
    timeprecision 100ps;

    // every accepted req comes back after the pipeline depth.
    req_gives_ack: assert property (@(posedge clk) disable iff (rst)
        $past(req, `FP_LATENCY) |-> ack)
        else $error("no ack %0d cycles after req", `FP_LATENCY);

    // an ack always belongs to a req.
    ack_has_req: assert property (@(posedge clk) disable iff (rst)
        ack |-> $past(req, `FP_LATENCY))
        else $error("ack without a req %0d cycles earlier", `FP_LATENCY);

    ack_low_in_reset: assert property (@(posedge clk)
        rst |-> !ack)
        else $error("ack high while reset is active");

    // result only moves together with ack.
    out_held: assert property (@(posedge clk) disable iff (rst)
        !ack |-> $stable(out))
        else $error("out changed between acks");

endmodule

`default_nettype wire

/* verif/float_add_tb.sv */
/*
 testbench for the pipelined float adder.
 directed and random operand pairs, checked against a real-number model.
*/
`default_nettype none

`include "fp_add_cfg.svh"

module float_add_tb import fp_add_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_RANDOM      = 40;
    localparam int NUM_VECTORS     = 22 + NUM_RANDOM;
    localparam int WATCHDOG_CYCLES = NUM_VECTORS * (`FP_LATENCY + 4) + 60;

    // one request in flight.
    typedef struct packed {
        logic [`FP_WORD_W-1:0] a;
        logic [`FP_WORD_W-1:0] b;
        logic [`FP_WORD_W-1:0] want;  // bit exact result.
        logic                  exact; // else checked within tolerance.
        int                    req_cycle;
    } vec_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     req;
    fp_word_u a_in;
    fp_word_u b_in;
    logic     ack;
    fp_word_u out;

    vec_t   pending[$];
    int     cycle_cnt = 0;
    int     ack_cnt   = 0;
    int     pass_cnt  = 0;
    int     fail_cnt  = 0;
    int     test_pass0;
    int     test_fail0;
    integer seed;

    always #(CLK_PERIOD / 2) clk = ~clk;

    float_add_pipeline uut (
        .clk (clk),
        .rst (rst),
        .req (req),
        .a   (a_in),
        .b   (b_in),
        .ack (ack),
        .out (out)
    );

    bind float_add_pipeline float_add_chk u_chk (
        .clk (clk),
        .rst (rst),
        .req (req),
        .ack (ack),
        .out (out)
    );

    // double to single by rebiasing the exponent and cutting the fraction.
    function automatic logic [`FP_WORD_W-1:0] to_float(input real r);
        logic [63:0]           d;
        int                    e;
        logic [`FP_WORD_W-1:0] f;
        d = $realtobits(r);
        e = int'(d[62:52]) - 1023 + `FP_BIAS;
        f = {d[63], {(`FP_WORD_W-1){1'b0}}};
        if (d[62:52] != '0 && e > 0 && e < 255) begin
            f = {d[63], e[7:0], d[51:29]};
        end
        return f;
    endfunction

    function automatic real to_real(input logic [`FP_WORD_W-1:0] f);
        logic [10:0] e;
        real         r;
        e = 11'(int'(f[30:23]) - `FP_BIAS + 1023);
        r = 0.0;
        if (f[30:23] != '0) begin
            r = $bitstoreal({f[31], e, f[22:0], 29'b0});
        end
        return r;
    endfunction

    function automatic real magnitude(input real r);
        return (r < 0.0) ? -r : r;
    endfunction

    // exponent 100..150, any sign and fraction.
    function automatic logic [`FP_WORD_W-1:0] random_operand();
        logic [31:0] pick_sign;
        logic [31:0] pick_exp;
        logic [31:0] pick_frac;
        pick_sign = $random(seed);
        pick_exp  = {$random(seed)} % 51;
        pick_frac = $random(seed);
        return {pick_sign[0], 8'(100 + pick_exp), pick_frac[22:0]};
    endfunction

    task automatic match_bits(input vec_t v);
        assert (out.bits == v.want) begin
            pass_cnt++;
        end else begin
            $display("ERROR out: got %h, expected %h (a %h, b %h)",
                     out.bits, v.want, v.a, v.b);
            fail_cnt++;
        end
    endtask

    task automatic match_near(input vec_t v);
        real exact;
        real err;
        exact = to_real(v.a) + to_real(v.b);
        err   = magnitude(to_real(out.bits) - exact);
        if (magnitude(exact) < to_real(32'h0080_0000)) begin
            assert (out.bits[`FP_WORD_W-2:0] == '0) begin
                pass_cnt++;
            end else begin
                $display("ERROR out: got %h, expected a signed zero (a %h, b %h)",
                         out.bits, v.a, v.b);
                fail_cnt++;
            end
        end else begin
            // relative error bound of 2^-23.
            assert (err <= magnitude(exact) * to_real(32'h3400_0000)) begin
                pass_cnt++;
            end else begin
                $display("ERROR out: got %h, expected near %h (a %h, b %h)",
                         out.bits, to_float(exact), v.a, v.b);
                fail_cnt++;
            end
        end
    endtask

    task automatic score_ack();
        vec_t v;
        assert (pending.size() != 0) else begin
            $display("ack at cycle %0d has no pending request", cycle_cnt);
            fail_cnt++;
        end
        if (pending.size() != 0) begin
            v = pending.pop_front(); // results come back in order.
            assert (cycle_cnt - v.req_cycle == `FP_LATENCY) else begin
                $display("ack came %0d cycles after its req instead of %0d",
                         cycle_cnt - v.req_cycle, `FP_LATENCY);
                fail_cnt++;
            end
            if (v.exact) begin
                match_bits(v);
            end else begin
                match_near(v);
            end
        end
    endtask

    // ack and out are read before this edge updates them.
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (ack) begin
            ack_cnt = ack_cnt + 1;
            score_ack();
        end
    end

    task automatic send_pair(input logic [`FP_WORD_W-1:0] op_a,
                             input logic [`FP_WORD_W-1:0] op_b,
                             input logic [`FP_WORD_W-1:0] want,
                             input logic                  exact);
        vec_t v;
        @(posedge clk);
        #2;
        req         = 1'b1;
        a_in.bits   = op_a;
        b_in.bits   = op_b;
        v.a         = op_a;
        v.b         = op_b;
        v.want      = want;
        v.exact     = exact;
        v.req_cycle = cycle_cnt + 1; // sampled at the coming edge.
        pending.push_back(v);
    endtask

    task automatic end_stream();
        @(posedge clk);
        #2;
        req = 1'b0;
        while (pending.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic start_test();
        test_pass0 = pass_cnt;
        test_fail0 = fail_cnt;
    endtask

    task automatic report_test(input string name);
        $display("test %s: %0d checks, %0d errors", name,
                 pass_cnt + fail_cnt - test_pass0 - test_fail0, fail_cnt - test_fail0);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int                    acks_seen;
        logic [`FP_WORD_W-1:0] op_x;
        logic [`FP_WORD_W-1:0] op_y;
        rst       = 1'b1;
        req       = 1'b0;
        a_in.bits = '0;
        b_in.bits = '0;
        seed      = 11525;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        start_test();
        send_pair(to_float(1.0), to_float(1.0), 32'h4000_0000, 1'b1);
        send_pair(to_float(2.0), to_float(3.0), 32'h40A0_0000, 1'b1);
        send_pair(to_float(2000.0), to_float(300.0), 32'h450F_C000, 1'b1);
        send_pair(to_float(-5.5), to_float(-3.25), 32'hC10C_0000, 1'b1);
        send_pair(to_float(1.5), to_float(-1.25), 32'h3E80_0000, 1'b1);
        send_pair(to_float(1.25), to_float(-1.5), 32'hBE80_0000, 1'b1);
        end_stream();
        report_test("exact sums");

        start_test();
        send_pair(to_float(3.5), to_float(-3.5), 32'h0000_0000, 1'b1);
        send_pair(32'h0000_0000, to_float(7.0), 32'h40E0_0000, 1'b1);
        send_pair(32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b1);
        send_pair(32'h8000_0000, 32'h8000_0000, 32'h0000_0000, 1'b1);
        send_pair(32'h0000_0000, to_float(-2.5), 32'hC020_0000, 1'b1);
        end_stream();
        report_test("cancellation and zeros");

        start_test();
        send_pair(32'h3F80_0000, 32'h3080_0000, 32'h3F80_0000, 1'b1); // sticky only.
        send_pair(32'h3F80_0000, 32'h3380_0000, 32'h3F80_0000, 1'b1); // tie, stays even.
        send_pair(32'h3F80_0001, 32'h3380_0000, 32'h3F80_0002, 1'b1); // tie, goes up.
        send_pair(32'h7F60_0000, 32'h7F60_0000, 32'h7F80_0000, 1'b1);
        send_pair(32'h0080_0001, 32'h8080_0000, '0, 1'b0); // cancels below the normal range.
        end_stream();
        report_test("alignment and rounding");

        start_test();
        send_pair(to_float(1.23), to_float(2.56), '0, 1'b0);
        send_pair(to_float(1.23), to_float(0.00456), '0, 1'b0);
        send_pair(to_float(-5.1), to_float(-3.2), '0, 1'b0);
        end_stream();
        report_test("reference values");

        // back to back, one req per cycle.
        start_test();
        for (int i = 0; i < NUM_RANDOM; i++) begin
            op_x = random_operand();
            op_y = random_operand();
            send_pair(op_x, op_y, '0, 1'b0);
        end
        end_stream();
        report_test("random stream");

        start_test();
        send_pair(to_float(1.0), to_float(1.0), 32'h4000_0000, 1'b1);
        send_pair(to_float(2.0), to_float(3.0), 32'h40A0_0000, 1'b1);
        @(posedge clk);
        #2;
        req = 1'b0;
        rst = 1'b1;
        pending.delete(); // both sums are dropped.
        acks_seen = ack_cnt;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (6) @(negedge clk);
        assert (ack_cnt == acks_seen) begin
            pass_cnt++;
        end else begin
            $display("acks appeared for requests discarded by reset");
            fail_cnt++;
        end
        send_pair(to_float(2000.0), to_float(300.0), 32'h450F_C000, 1'b1);
        end_stream();
        report_test("reset in flight");

        $display("done: %0d checks passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+source
source/fp_add_pkg.sv
source/fp_align.sv
source/fp_mant_add.sv
source/fp_round_pack.sv
source/float_add_pipeline.sv
verif/float_add_chk.sv
verif/float_add_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the float adder testbench with verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --timescale 1ns/100ps \
    --top-module float_add_tb \
    -f verilog.f \
    -o float_add_sim

# the log decides the outcome, not the exit status.
./obj_dir/float_add_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
